//--- testbench/rvCoreTests.txt
# P address word0 word1 word2 word3 : four program words from address
# S address data mask : expected store, data masked to the active lanes
P 000 123450B7 FFB00113 00700193 40218233
P 010 40018293 60402023 60502223 00312333
P 020 003133B3 0020C433 0551E013 006404B3
P 030 007484B3 000484B3 60902423 0011E533
P 040 7F017593 00B50533 60A02623 01F19613
P 050 40115693 01F15713 000097B3 41F65813
P 060 00E658B3 60C02823 60D02A23 60E02C23
P 070 60F02E23 63002023 63102223 00318463
P 080 100A0A13 00218463 001A0A13 00219463
P 090 100A0A13 00319463 002A0A13 00314463
P 0A0 100A0A13 0021C463 004A0A13 0021D463
P 0B0 100A0A13 00315463 008A0A13 0021E463
P 0C0 100A0A13 00316463 010A0A13 00317463
P 0D0 100A0A13 0021F463 020A0A13 63402423
P 0E0 00001A97 00C00B6F 100A0A13 100A0A13
P 0F0 10000BE7 100A0A13 100A0A13 100A0A13
P 100 016A8C33 017C0C33 63802623 63402823
P 110 A1B2CCB7 3D4C8C93 65900023 659000A3
P 120 65900123 659001A3 65901223 65901323
P 130 64100D03 64304D83 64601E03 64405E83
P 140 64402F03 65A02423 65B02623 65C02823
P 150 65D02A23 65E02C23 00400FB7 019FA223
P 160 64302E23 0000006F 00000013 00000013
S 600 0000000C F
S 604 00000407 F
S 608 EDCBAFFC F
S 60C 123457F7 F
S 610 80000000 F
S 614 FFFFFFFD F
S 618 00000001 F
S 61C 12345000 F
S 620 FFFFFFFF F
S 624 40000000 F
S 628 0000003F F
S 62C 000012BC F
S 630 0000003F F
S 640 000000D4 1
S 641 0000D400 2
S 642 00D40000 4
S 643 D4000000 8
S 644 0000C3D4 3
S 646 C3D40000 C
S 648 FFFFFFD4 F
S 64C 000000D4 F
S 650 FFFFC3D4 F
S 654 0000C3D4 F
S 658 C3D4C3D4 F
S 400004 A1B2C3D4 F
S 65C 00000007 F

//--- rvCore.f
src/rvIsaPkg.sv
src/rvCorePkg.sv
src/rvDecoder.sv
src/rvAlu.sv
src/rvRegFile.sv
src/rvLoadStore.sv
src/rvCore.sv
testbench/rvCoreTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the RV32I core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module rvCoreTb -f rvCore.f -o rvCoreSim &&
./obj_dir/rvCoreSim | tee /dev/stderr | grep -q "TEST OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- testbench/rvCoreTb.sv
// ****************************************
// RV32I core testbench
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module rvCoreTb;

   localparam int clkPeriod = 100;
   localparam int memWords  = 512;        // 2 KB at address zero
   localparam int wordLimit = 200;        // Watchdog cycles per program word

   logic               clk;
   logic               reset;
   rvCorePkg::memReq_t memReq;
   rvCorePkg::memRsp_t memRsp;

   rvIsaPkg::word_t   mem [memWords];
   rvIsaPkg::word_t   expAddr [$];        // Expected stores, in order
   rvIsaPkg::word_t   expData [$];        // Already masked to the lanes
   rvCorePkg::wmask_t expMask [$];
   int                progWords;
   int                rbusyCnt;
   int                wbusyCnt;
   logic [31:0]       rngState;
   logic              fetchSeen;
   logic              loaded;
   logic              storesDone;

   rvCore dut0 (
      .clk   (clk),
      .reset (reset),
      .memReq(memReq),
      .memRsp(memRsp)
   );

   always #(clkPeriod / 2) clk = ~clk;

   // ****************************************
   // Helpers
   // ****************************************
   function automatic logic [31:0] nextRand(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;  // LCG step
   endfunction

   function automatic rvIsaPkg::word_t laneBits(input rvCorePkg::wmask_t m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "Value mismatch");
      end
   endtask

   // Draws a busy length of 1 to 3 cycles about a quarter of the time
   task automatic drawBusy(output int cnt);
      rngState = nextRand(rngState);
      cnt = (rngState[17:16] == 2'b00) ? 1 + int'(rngState[20:19]) % 3 : 0;
   endtask

   // ****************************************
   // Test file
   // ****************************************
   task automatic loadTests();
      int          fd;
      string       line;
      logic [31:0] a;
      logic [31:0] w [4];
      fd = $fopen("testbench/rvCoreTests.txt", "r");
      if (fd == 0) begin
         $display("Could not open the test file testbench/rvCoreTests.txt");
         $display("TEST FAILED");
         $fatal(1, "No test file");
      end
      while ($fgets(line, fd) != 0) begin
         if ($sscanf(line, "P %h %h %h %h %h", a, w[0], w[1], w[2], w[3]) == 5) begin
            for (int k = 0; k < 4; k++) begin
               mem[int'(a[10:2]) + k] = w[k];
               progWords++;
            end
         end else if ($sscanf(line, "S %h %h %h", a, w[0], w[1]) == 3) begin
            expAddr.push_back(a);
            expData.push_back(w[0]);
            expMask.push_back(w[1][3:0]);
         end
      end
      $fclose(fd);
   endtask

   // ****************************************
   // Memory model, driven on the falling edge
   // ****************************************
   always @(negedge clk) begin : memModel
      int idx;
      idx = int'(memReq.addr[10:2]);
      if (reset && loaded) begin
         if (rbusyCnt > 0) rbusyCnt--;
         if (wbusyCnt > 0) wbusyCnt--;
         // Write cycle, checked against the next expected store
         if (memReq.wmask != '0) begin
            if (!fetchSeen) begin
               $display("A write happened before the first instruction fetch");
               $display("TEST FAILED");
               $fatal(1, "Early write");
            end
            if (expAddr.size() > 0) begin
               checkValue("memReq.addr", memReq.addr, expAddr[0]);
               checkValue("memReq.wmask", 32'(memReq.wmask), 32'(expMask[0]));
               checkValue("memReq.wdata", memReq.wdata & laneBits(memReq.wmask), expData[0]);
               void'(expAddr.pop_front());
               void'(expData.pop_front());
               void'(expMask.pop_front());
               if (expAddr.size() == 0) storesDone = 1'b1;
            end
            if (memReq.addr[rvIsaPkg::ioSelHi:rvIsaPkg::ioSelLo] == 2'b00) begin
               for (int b = 0; b < 4; b++) begin
                  if (memReq.wmask[b]) mem[idx][8*b +: 8] = memReq.wdata[8*b +: 8];
               end
            end
            drawBusy(wbusyCnt);
         end
         // Read strobe, data shows up for the next cycle
         if (memReq.rstrb) begin
            if (!fetchSeen) begin
               checkValue("memReq.addr", memReq.addr, 32'(rvIsaPkg::resetAddr));
               fetchSeen = 1'b1;
            end
            memRsp.rdata = mem[idx];
            drawBusy(rbusyCnt);
         end
         memRsp.rbusy = (rbusyCnt != 0);
         memRsp.wbusy = (wbusyCnt != 0);
      end else if (!reset) begin
         // Bus stays idle while reset is held
         checkValue("memReq.rstrb", 32'(memReq.rstrb), 32'd0);
         checkValue("memReq.wmask", 32'(memReq.wmask), 32'd0);
      end
   end

   // ****************************************
   // Watchdog
   // ****************************************
   initial begin
      wait (loaded);
      #(progWords * wordLimit * clkPeriod);
      $display("Watchdog expired, the program did not finish its stores");
      $display("TEST FAILED");
      $fatal(1, "Timeout");
   end

   // ****************************************
   // Main sequence
   // ****************************************
   initial begin
      clk        = 1'b0;
      reset      = 1'b0;                  // Active low
      memRsp     = '0;
      rbusyCnt   = 0;
      wbusyCnt   = 0;
      rngState   = 32'ha6d0;
      fetchSeen  = 1'b0;
      storesDone = 1'b0;
      progWords  = 0;
      loaded     = 1'b0;
      for (int i = 0; i < memWords; i++) begin
         mem[i] = rvIsaPkg::word_t'(i) * 32'h9e3779b9 ^ 32'h5a5a0000; // Fill by address
      end
      loadTests();
      loaded = 1'b1;
      repeat (4) @(negedge clk);
      reset = 1'b1;
      wait (storesDone);
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- src/rvCore.sv
// ****************************************
// Multi-cycle RV32I core
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module rvCore (
   input  logic               clk,
   input  logic               reset,
   output rvCorePkg::memReq_t memReq,
   input  rvCorePkg::memRsp_t memRsp
);

   rvCorePkg::coreState_t state;
   rvCorePkg::decoded_t   dec;
   rvIsaPkg::addr_t       pc;
   rvIsaPkg::addr_t       pcPlus4;
   rvIsaPkg::addr_t       addrReg;      // Drives the memory address
   rvIsaPkg::addr_t       addrAdderIn1;
   rvIsaPkg::addr_t       addrAdderIn2;
   rvIsaPkg::addr_t       addrAdderOut; // Registered pc or rs1 plus imm
   rvIsaPkg::word_t       instr;
   rvIsaPkg::regIdx_t     fetchRs1;
   rvIsaPkg::regIdx_t     fetchRs2;
   rvIsaPkg::word_t       rs1Data;
   rvIsaPkg::word_t       rs2Data;
   rvIsaPkg::word_t       aluIn2;
   rvIsaPkg::word_t       aluResult;
   rvIsaPkg::word_t       loadData;
   rvIsaPkg::word_t       storeWdata;
   rvIsaPkg::word_t       writeBackData;
   rvCorePkg::wmask_t     storeWmask;
   logic                  regRdEn;
   logic                  aluStart;
   logic                  aluPred;
   logic                  aluBusy;
   logic                  isAlu;
   logic                  writeBack;
   logic                  jumpOrTake;
   logic                  isIoAddr;

   // ****************************************
   // Submodules
   // ****************************************
   rvDecoder decoder0 (
      .instr(instr),
      .dec  (dec)
   );

   // Indices straight from the bus so values land in fetchRegs
   assign fetchRs1 = memRsp.rdata[19:15];
   assign fetchRs2 = memRsp.rdata[24:20];
   assign regRdEn  = (state == rvCorePkg::waitInstr) & !memRsp.rbusy;

   rvRegFile regFile0 (
      .clk    (clk),
      .rdEn   (regRdEn),
      .rs1    (fetchRs1),
      .rs2    (fetchRs2),
      .rd     (dec.rd),
      .we     (writeBack),
      .wdata  (writeBackData),
      .rs1Data(rs1Data),
      .rs2Data(rs2Data)
   );

   assign isAlu    = dec.isAluImm | dec.isAluReg;
   assign aluIn2   = (dec.isAluReg | dec.isBranch) ? rs2Data : dec.immI;
   assign aluStart = (state == rvCorePkg::addrAndAlu) & isAlu;

   rvAlu alu0 (
      .clk      (clk),
      .reset    (reset),
      .start    (aluStart),
      .latchPred(state == rvCorePkg::addrAndAlu),
      .in1      (rs1Data),
      .in2      (aluIn2),
      .funct3   (dec.funct3),
      .subtract (dec.altOp & dec.regOp),   // ADDI may have bit 30 set
      .arith    (dec.altOp),
      .result   (aluResult),
      .predicate(aluPred),
      .busy     (aluBusy)
   );

   rvLoadStore loadStore0 (
      .addrLow  (addrReg[1:0]),
      .funct3   (dec.funct3),
      .storeData(rs2Data),
      .rdata    (memRsp.rdata),
      .loadData (loadData),
      .wdata    (storeWdata),
      .wmask    (storeWmask)
   );

   // ****************************************
   // Address and write-back datapath
   // ****************************************
   assign pcPlus4 = pc + rvIsaPkg::addr_t'(4);

   assign addrAdderIn1 = (dec.isLoad | dec.isStore | dec.isJalr) ?
                         rs1Data[rvIsaPkg::addrWidth-1:0] : pc;
   assign addrAdderIn2 = dec.isJal    ? dec.immJ[rvIsaPkg::addrWidth-1:0] :
                         dec.isAuipc  ? dec.immU[rvIsaPkg::addrWidth-1:0] :
                         dec.isStore  ? dec.immS[rvIsaPkg::addrWidth-1:0] :
                         dec.isBranch ? dec.immB[rvIsaPkg::addrWidth-1:0] :
                                        dec.immI[rvIsaPkg::addrWidth-1:0]; // Load, JALR

   assign writeBackData = (dec.isLui                ? dec.immU                        : '0) |
                          (isAlu                    ? aluResult                       : '0) |
                          (dec.isAuipc              ? rvIsaPkg::word_t'(addrAdderOut) : '0) |
                          (dec.isJal | dec.isJalr   ? rvIsaPkg::word_t'(pcPlus4)      : '0) |
                          (dec.isLoad               ? loadData                        : '0);

   // Last write in waitAluOrMem holds the final shift or load value
   assign writeBack = !(dec.isBranch | dec.isStore) &
                      ((state == rvCorePkg::execute) | (state == rvCorePkg::waitAluOrMem));

   assign jumpOrTake = dec.isJal | dec.isJalr | (dec.isBranch & aluPred);
   assign isIoAddr   = addrReg[rvIsaPkg::ioSelHi] | addrReg[rvIsaPkg::ioSelLo];

   assign memReq = '{
      addr:  rvIsaPkg::word_t'(addrReg),
      wdata: storeWdata,
      wmask: (state == rvCorePkg::store) ? storeWmask : '0,
      rstrb: (state == rvCorePkg::fetchInstr) | (state == rvCorePkg::load)
   };

   // ****************************************
   // Sequencer
   // ****************************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= rvCorePkg::waitAluOrMem;  // Waits for wbusy low, then fetches
         pc    <= rvIsaPkg::resetAddr;
      end else begin
         case (state)
            rvCorePkg::fetchInstr: state <= rvCorePkg::waitInstr;
            rvCorePkg::waitInstr: begin
               if (!memRsp.rbusy) begin
                  instr <= memRsp.rdata;
                  state <= rvCorePkg::fetchRegs;
               end
            end
            rvCorePkg::fetchRegs: state <= rvCorePkg::addrAndAlu;
            rvCorePkg::addrAndAlu: begin
               addrAdderOut <= addrAdderIn1 + addrAdderIn2;
               state        <= rvCorePkg::execute;
            end
            rvCorePkg::execute: begin
               pc      <= jumpOrTake ? addrAdderOut : pcPlus4;
               addrReg <= (dec.isLoad | dec.isStore | jumpOrTake) ? addrAdderOut : pcPlus4;
               if (dec.isStore) begin
                  state <= rvCorePkg::store;
               end else if (dec.isLoad) begin
                  state <= rvCorePkg::load;
               end else if (aluBusy) begin
                  state <= rvCorePkg::waitAluOrMem;   // Shift still running
               end else begin
                  state <= rvCorePkg::fetchInstr;
               end
            end
            rvCorePkg::load: state <= rvCorePkg::waitAluOrMem;
            rvCorePkg::store: begin
               addrReg <= pc;
               if (isIoAddr) begin
                  state <= rvCorePkg::waitAluOrMem;   // Hold until wbusy falls
               end else begin
                  state <= rvCorePkg::fetchInstr;
               end
            end
            rvCorePkg::waitAluOrMem: begin
               if (!aluBusy & !memRsp.rbusy & !memRsp.wbusy) begin
                  addrReg <= pc;
                  state   <= rvCorePkg::fetchInstr;
               end
            end
            default: state <= rvCorePkg::waitAluOrMem;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/rvLoadStore.sv
// ****************************************
// Load and store alignment
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module rvLoadStore (
   input  logic [1:0]        addrLow,   // Byte offset in the word
   input  rvIsaPkg::funct3_t funct3,    // Bits 1:0 size, bit 2 unsigned
   input  rvIsaPkg::word_t   storeData,
   input  rvIsaPkg::word_t   rdata,
   output rvIsaPkg::word_t   loadData,
   output rvIsaPkg::word_t   wdata,
   output rvCorePkg::wmask_t wmask
);

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // ****************************************
   // Load path
   // ****************************************
   assign loadHalf = addrLow[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]); // LBU, LHU zero fill

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  rdata;

   // ****************************************
   // Store path
   // ****************************************
   // Low bytes repeated so every lane sees its data
   assign wdata[7:0]   = storeData[7:0];
   assign wdata[15:8]  = addrLow[0] ? storeData[7:0] : storeData[15:8];
   assign wdata[23:16] = addrLow[1] ? storeData[7:0] : storeData[23:16];
   assign wdata[31:24] = addrLow[0] ? storeData[7:0] :
                         addrLow[1] ? storeData[15:8] :
                                      storeData[31:24];

   // One, two or four lanes
   assign wmask = byteAccess ? rvCorePkg::wmask_t'(4'b0001 << addrLow) :
                  halfAccess ? (addrLow[1] ? 4'b1100 : 4'b0011) :
                               4'b1111;

endmodule

`default_nettype wire

//--- src/rvRegFile.sv
// ****************************************
// Register file
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module rvRegFile (
   input  logic              clk,
   input  logic              rdEn,     // Registered read of both ports
   input  rvIsaPkg::regIdx_t rs1,
   input  rvIsaPkg::regIdx_t rs2,
   input  rvIsaPkg::regIdx_t rd,
   input  logic              we,
   input  rvIsaPkg::word_t   wdata,
   output rvIsaPkg::word_t   rs1Data,
   output rvIsaPkg::word_t   rs2Data
);

   rvIsaPkg::word_t regs [32];

   // All registers start at zero, x0 stays there
   initial begin
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
   end

   always @(posedge clk) begin
      if (we && (rd != '0)) begin
         regs[rd] <= wdata;           // x0 writes dropped
      end
   end

   // Read data one cycle after rdEn
   always_ff @(posedge clk) begin
      if (rdEn) begin
         rs1Data <= regs[rs1];
         rs2Data <= regs[rs2];
      end
   end

endmodule

`default_nettype wire

//--- src/rvAlu.sv
// ****************************************
// ALU with serial shifter
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module rvAlu (
   input  logic              clk,
   input  logic              reset,
   input  logic              start,     // Register result or begin shift
   input  logic              latchPred, // Capture branch condition
   input  rvIsaPkg::word_t   in1,
   input  rvIsaPkg::word_t   in2,
   input  rvIsaPkg::funct3_t funct3,
   input  logic              subtract,
   input  logic              arith,     // Sign fill on right shift
   output rvIsaPkg::word_t   result,
   output logic              predicate,
   output logic              busy
);

   rvIsaPkg::word_t  acc;              // Result register
   rvIsaPkg::shamt_t shamt;            // Shift steps left
   rvIsaPkg::word_t  plus;
   logic [32:0]      minus;            // Bit 32 is the borrow, set when in1 < in2
   logic             lt;
   logic             ltu;
   logic             eq;
   logic             isShift;

   assign plus  = in1 + in2;
   assign minus = {1'b1, ~in2} + {1'b0, in1} + 33'd1; // One subtractor for all compares

   assign lt  = (in1[31] ^ in2[31]) ? in1[31] : minus[32];
   assign ltu = minus[32];
   assign eq  = (minus[31:0] == '0);

   assign isShift = (funct3[1:0] == 2'b01); // SLL, SRL, SRA
   assign result  = acc;
   assign busy    = |shamt;

   // ****************************************
   // Shift counter
   // ****************************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         shamt <= '0;
      end else if (start) begin
         shamt <= isShift ? in2[4:0] : '0;
      end else if (busy) begin
         shamt <= shamt - 1'b1;           // One bit per cycle
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         case (funct3)
            3'b000:         acc <= subtract ? minus[31:0] : plus; // ADD, SUB
            3'b010:         acc <= {31'b0, lt};                   // SLT
            3'b011:         acc <= {31'b0, ltu};                  // SLTU
            3'b100:         acc <= in1 ^ in2;
            3'b110:         acc <= in1 | in2;
            3'b111:         acc <= in1 & in2;
            default:        acc <= in1;                           // Shift operand
         endcase
      end else if (busy) begin
         // Right for SRL and SRA, left for SLL
         acc <= funct3[2] ? {arith & acc[31], acc[31:1]} : {acc[30:0], 1'b0};
      end
   end

   // ****************************************
   // Branch condition
   // ****************************************
   always_ff @(posedge clk) begin
      if (latchPred) begin
         case (funct3)
            3'b000:  predicate <= eq;    // BEQ
            3'b001:  predicate <= !eq;   // BNE
            3'b100:  predicate <= lt;    // BLT
            3'b101:  predicate <= !lt;   // BGE
            3'b110:  predicate <= ltu;   // BLTU
            3'b111:  predicate <= !ltu;  // BGEU
            default: predicate <= 1'b0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/rvDecoder.sv
// ****************************************
// RV32I instruction decoder
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module rvDecoder (
   input  rvIsaPkg::word_t     instr,
   output rvCorePkg::decoded_t dec
);

   rvIsaPkg::opcode_t opcode;

   assign opcode = rvIsaPkg::opcode_t'(instr[6:2]); // Bits 1:0 are always 11

   always_comb begin
      // ****************************************
      // Instruction class, at most one flag set
      // ****************************************
      dec.isLoad   = (opcode == rvIsaPkg::opLoad);
      dec.isAluImm = (opcode == rvIsaPkg::opAluImm);
      dec.isAuipc  = (opcode == rvIsaPkg::opAuipc);
      dec.isStore  = (opcode == rvIsaPkg::opStore);
      dec.isAluReg = (opcode == rvIsaPkg::opAluReg);
      dec.isLui    = (opcode == rvIsaPkg::opLui);
      dec.isBranch = (opcode == rvIsaPkg::opBranch);
      dec.isJalr   = (opcode == rvIsaPkg::opJalr);
      dec.isJal    = (opcode == rvIsaPkg::opJal);

      // Register indices and subcodes
      dec.rd     = instr[11:7];
      dec.rs1    = instr[19:15];
      dec.rs2    = instr[24:20];
      dec.funct3 = instr[14:12];
      dec.altOp  = instr[30];
      dec.regOp  = instr[5];         // Tells SUB from ADDI with bit 30 set

      // ****************************************
      // Immediates, sign from bit 31
      // ****************************************
      dec.immU = {instr[31:12], 12'b0};
      dec.immI = {{21{instr[31]}}, instr[30:20]};
      dec.immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      dec.immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      dec.immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   end

endmodule

`default_nettype wire

//--- src/rvCorePkg.sv
// ****************************************
// Core microarchitecture types
// ****************************************
`default_nettype none

package rvCorePkg;

   // Sequencer states, one bit per state
   typedef enum logic [7:0] {
      fetchInstr   = 8'b0000_0001,   // Fetch strobe, instruction in flight
      waitInstr    = 8'b0000_0010,   // Latch instruction when rbusy is low
      fetchRegs    = 8'b0000_0100,   // Register values in flight
      execute      = 8'b0000_1000,   // Next pc and branch point
      load         = 8'b0001_0000,   // Data read strobe
      waitAluOrMem = 8'b0010_0000,   // Shift, load data or IO write
      store        = 8'b0100_0000,   // Write mask active
      addrAndAlu   = 8'b1000_0000    // Address add and ALU start
   } coreState_t;

   typedef logic [3:0] wmask_t;      // One bit per byte lane

   // Core to memory
   typedef struct packed {
      rvIsaPkg::word_t addr;
      rvIsaPkg::word_t wdata;
      wmask_t          wmask;        // Nonzero for exactly the write cycle
      logic            rstrb;        // Starts a read
   } memReq_t;

   // Memory to core
   typedef struct packed {
      rvIsaPkg::word_t rdata;
      logic            rbusy;
      logic            wbusy;
   } memRsp_t;

   // Decoded instruction fields
   typedef struct packed {
      logic              isLoad;
      logic              isAluImm;
      logic              isAuipc;
      logic              isStore;
      logic              isAluReg;
      logic              isLui;
      logic              isBranch;
      logic              isJalr;
      logic              isJal;
      rvIsaPkg::regIdx_t rd;
      rvIsaPkg::regIdx_t rs1;
      rvIsaPkg::regIdx_t rs2;
      rvIsaPkg::funct3_t funct3;
      logic              altOp;      // Bit 30, SUB and SRA
      logic              regOp;      // Bit 5, register operand
      rvIsaPkg::word_t   immU;
      rvIsaPkg::word_t   immI;
      rvIsaPkg::word_t   immS;
      rvIsaPkg::word_t   immB;
      rvIsaPkg::word_t   immJ;
   } decoded_t;

endpackage

`default_nettype wire

//--- src/rvIsaPkg.sv
// ****************************************
// RV32I encoding definitions
// ****************************************
`default_nettype none

package rvIsaPkg;

   // ****************************************
   // Address space
   // ****************************************
   localparam int addrWidth = 24;   // Internal address bus width
   localparam int ioSelHi = 23;     // Mapped IO select, upper bit
   localparam int ioSelLo = 22;     // Mapped IO select, lower bit

   typedef logic [addrWidth-1:0] addr_t;

   localparam addr_t resetAddr = '0; // First fetch address

   // ****************************************
   // Data and field types
   // ****************************************
   typedef logic [31:0] word_t;      // Register and bus word
   typedef logic [4:0]  regIdx_t;    // x0..x31
   typedef logic [2:0]  funct3_t;    // Operation subcode
   typedef logic [4:0]  shamt_t;     // Shift amount

   // Major opcode, instruction bits 6:2
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,           // rd <- mem[rs1 + immI]
      opAluImm = 5'b00100,           // rd <- rs1 op immI
      opAuipc  = 5'b00101,           // rd <- pc + immU
      opStore  = 5'b01000,           // mem[rs1 + immS] <- rs2
      opAluReg = 5'b01100,           // rd <- rs1 op rs2
      opLui    = 5'b01101,           // rd <- immU
      opBranch = 5'b11000,           // Conditional pc + immB
      opJalr   = 5'b11001,           // rd <- pc + 4, pc <- rs1 + immI
      opJal    = 5'b11011            // rd <- pc + 4, pc <- pc + immJ
   } opcode_t;

endpackage

`default_nettype wire
